/* datapath_defines.svh */
`ifndef DATAPATH_DEFINES_SVH
`define DATAPATH_DEFINES_SVH

// width of a data word and of everything on the bus
`define WORD_WIDTH 32

// general register file
`define REG_COUNT 16
`define REG_INDEX_WIDTH 4

// immediate field in IR bits 18..0
`define CONST_WIDTH 19

`endif

/* datapathPkg.sv */
`include "datapath_defines.svh"

package datapathPkg;

    // ALU operations, selected per cycle by the control word
    typedef enum logic [4:0] {
        opAnd,
        opOr,
        opAdd,
        opSub,
        opShl,
        opShr,
        opShra,
        opRol,
        opRor,
        opNot,
        opNeg,
        opMul,
        opInc   // bus plus one, used for PC increment
    } aluOpcode;

    // who drives the shared bus this cycle
    typedef enum logic [3:0] {
        srcNone,        // bus reads as zero
        srcRegister,    // general register picked by regIndex
        srcPc,
        srcMdr,
        srcZHigh,
        srcZLow,
        srcHi,
        srcLo,
        srcInPort,
        srcConstant     // sign-extended IR immediate
    } busSource;

    typedef struct packed {
        busSource                     source;
        logic [`REG_INDEX_WIDTH-1:0]  regIndex;
        logic [`REG_COUNT-1:0]        regLoad;   // one-hot, bit i loads Ri
        logic                         pcLoad;
        logic                         irLoad;
        logic                         marLoad;
        logic                         mdrLoad;
        logic                         read;      // MDR takes Mdatain instead of the bus
        logic                         yLoad;
        logic                         zLoad;
        logic                         hiLoad;
        logic                         loLoad;
        logic                         outPortLoad;
        aluOpcode                     opcode;
    } controlWord;

endpackage

/* registerFile.sv */
`include "datapath_defines.svh"

module registerFile (
    input  logic                     Clock,
    input  logic                     reset,
    input  datapathPkg::controlWord  control,
    input  logic [`WORD_WIDTH-1:0]   busData,
    output logic [`WORD_WIDTH-1:0]   readData
);

    logic [`WORD_WIDTH-1:0] registers [`REG_COUNT];

    // each register with its regLoad bit set captures the bus
    always_ff @(posedge Clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                registers[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                if (control.regLoad[i]) begin
                    registers[i] <= busData;
                end
            end
        end
    end

    // single read port, only goes on the bus when busSelector picks srcRegister
    assign readData = registers[control.regIndex];

endmodule

/* arithLogicUnit.sv */
`include "datapath_defines.svh"

module arithLogicUnit (
    input  datapathPkg::controlWord   control,
    input  logic [`WORD_WIDTH-1:0]    y,
    input  logic [`WORD_WIDTH-1:0]    busData,
    output logic [2*`WORD_WIDTH-1:0]  result
);

    import datapathPkg::*;

    localparam int ShiftBits = $clog2(`WORD_WIDTH);

    logic [ShiftBits-1:0]          shiftAmount;
    logic [2*`WORD_WIDTH-1:0]      rolWide;
    logic [2*`WORD_WIDTH-1:0]      rorWide;
    logic signed [2*`WORD_WIDTH-1:0] product;
    logic [`WORD_WIDTH-1:0]        lowWord;

    assign shiftAmount = busData[ShiftBits-1:0];   // only the low bits count

    // rotates done on a doubled copy of Y
    assign rolWide = {y, y} << shiftAmount;
    assign rorWide = {y, y} >> shiftAmount;

    // signed 32x32, full 64-bit product
    assign product = $signed(y) * $signed(busData);

    // single-word results
    always_comb begin
        case (control.opcode)
            opAnd:   lowWord = y & busData;
            opOr:    lowWord = y | busData;
            opAdd:   lowWord = y + busData;
            opSub:   lowWord = y - busData;
            opShl:   lowWord = y << shiftAmount;
            opShr:   lowWord = y >> shiftAmount;
            opShra:  lowWord = $signed(y) >>> shiftAmount;   // keeps the sign bit
            opRol:   lowWord = rolWide[2*`WORD_WIDTH-1:`WORD_WIDTH];
            opRor:   lowWord = rorWide[`WORD_WIDTH-1:0];
            opNot:   lowWord = ~busData;        // Y not involved
            opNeg:   lowWord = '0 - busData;    // two's complement of the bus
            opInc:   lowWord = busData + `WORD_WIDTH'd1;
            default: lowWord = '0;
        endcase
    end

    // multiply is the only op that fills the high half
    always_comb begin
        if (control.opcode == opMul) begin
            result = product;
        end else begin
            result = {{`WORD_WIDTH{1'b0}}, lowWord};
        end
    end

endmodule

/* specialRegisters.sv */
`include "datapath_defines.svh"

module specialRegisters (
    input  logic                      Clock,
    input  logic                      reset,
    input  datapathPkg::controlWord   control,
    input  logic [`WORD_WIDTH-1:0]    busData,
    input  logic [`WORD_WIDTH-1:0]    Mdatain,
    input  logic [2*`WORD_WIDTH-1:0]  aluResult,
    output logic [`WORD_WIDTH-1:0]    pc,
    output logic [`WORD_WIDTH-1:0]    ir,
    output logic [`WORD_WIDTH-1:0]    mdr,
    output logic [`WORD_WIDTH-1:0]    zHigh,
    output logic [`WORD_WIDTH-1:0]    zLow,
    output logic [`WORD_WIDTH-1:0]    hi,
    output logic [`WORD_WIDTH-1:0]    lo,
    output logic [`WORD_WIDTH-1:0]    y,
    output logic [`WORD_WIDTH-1:0]    memoryAddress,
    output logic [`WORD_WIDTH-1:0]    outPort
);

    logic [`WORD_WIDTH-1:0] mdrInput;

    // MDR read mux: memory side on a read, otherwise the bus
    assign mdrInput = control.read ? Mdatain : busData;

    always_ff @(posedge Clock) begin
        if (reset) begin
            pc            <= '0;
            ir            <= '0;
            mdr           <= '0;
            zHigh         <= '0;
            zLow          <= '0;
            hi            <= '0;
            lo            <= '0;
            y             <= '0;
            memoryAddress <= '0;
            outPort       <= '0;
        end else begin
            if (control.pcLoad) begin
                pc <= busData;
            end
            if (control.irLoad) begin
                ir <= busData;
            end
            if (control.marLoad) begin
                memoryAddress <= busData;   // MAR drives the address directly
            end
            if (control.mdrLoad) begin
                mdr <= mdrInput;
            end
            if (control.yLoad) begin
                y <= busData;
            end
            if (control.zLoad) begin
                zHigh <= aluResult[2*`WORD_WIDTH-1:`WORD_WIDTH];
                zLow  <= aluResult[`WORD_WIDTH-1:0];
            end
            if (control.hiLoad) begin
                hi <= busData;
            end
            if (control.loLoad) begin
                lo <= busData;
            end
            if (control.outPortLoad) begin
                outPort <= busData;
            end
        end
    end

endmodule

/* busSelector.sv */
`include "datapath_defines.svh"

module busSelector (
    input  datapathPkg::controlWord  control,
    input  logic [`WORD_WIDTH-1:0]   readData,
    input  logic [`WORD_WIDTH-1:0]   pc,
    input  logic [`WORD_WIDTH-1:0]   ir,
    input  logic [`WORD_WIDTH-1:0]   mdr,
    input  logic [`WORD_WIDTH-1:0]   zHigh,
    input  logic [`WORD_WIDTH-1:0]   zLow,
    input  logic [`WORD_WIDTH-1:0]   hi,
    input  logic [`WORD_WIDTH-1:0]   lo,
    input  logic [`WORD_WIDTH-1:0]   inPort,
    output logic [`WORD_WIDTH-1:0]   busData
);

    import datapathPkg::*;

    logic [`WORD_WIDTH-1:0] constant;

    // immediate from IR, sign bit is IR[18]
    assign constant = {{(`WORD_WIDTH-`CONST_WIDTH){ir[`CONST_WIDTH-1]}},
                       ir[`CONST_WIDTH-1:0]};

    // exactly one source per cycle, encoded so no two can collide
    always_comb begin
        case (control.source)
            srcRegister: busData = readData;
            srcPc:       busData = pc;
            srcMdr:      busData = mdr;
            srcZHigh:    busData = zHigh;
            srcZLow:     busData = zLow;
            srcHi:       busData = hi;
            srcLo:       busData = lo;
            srcInPort:   busData = inPort;
            srcConstant: busData = constant;
            default:     busData = '0;   // srcNone and unused codes
        endcase
    end

endmodule

/* datapath.sv */
`include "datapath_defines.svh"

module datapath (
    input  logic                     Clock,
    input  logic                     reset,
    input  datapathPkg::controlWord  control,
    input  logic [`WORD_WIDTH-1:0]   Mdatain,
    input  logic [`WORD_WIDTH-1:0]   inPort,
    output logic [`WORD_WIDTH-1:0]   busData,
    output logic [`WORD_WIDTH-1:0]   memoryAddress,
    output logic [`WORD_WIDTH-1:0]   instruction,
    output logic [`WORD_WIDTH-1:0]   outPort
);

    logic [`WORD_WIDTH-1:0]    readData;
    logic [`WORD_WIDTH-1:0]    pc;
    logic [`WORD_WIDTH-1:0]    mdr;
    logic [`WORD_WIDTH-1:0]    zHigh;
    logic [`WORD_WIDTH-1:0]    zLow;
    logic [`WORD_WIDTH-1:0]    hi;
    logic [`WORD_WIDTH-1:0]    lo;
    logic [`WORD_WIDTH-1:0]    y;
    logic [2*`WORD_WIDTH-1:0]  aluResult;

    // R0..R15
    registerFile registerFile_i (
        .Clock    (Clock),
        .reset    (reset),
        .control  (control),
        .busData  (busData),
        .readData (readData)
    );

    // IR output is the instruction port itself
    specialRegisters specialRegisters_i (
        .Clock         (Clock),
        .reset         (reset),
        .control       (control),
        .busData       (busData),
        .Mdatain       (Mdatain),
        .aluResult     (aluResult),
        .pc            (pc),
        .ir            (instruction),
        .mdr           (mdr),
        .zHigh         (zHigh),
        .zLow          (zLow),
        .hi            (hi),
        .lo            (lo),
        .y             (y),
        .memoryAddress (memoryAddress),
        .outPort       (outPort)
    );

    arithLogicUnit arithLogicUnit_i (
        .control (control),
        .y       (y),
        .busData (busData),
        .result  (aluResult)
    );

    // the only driver of the shared bus
    busSelector busSelector_i (
        .control  (control),
        .readData (readData),
        .pc       (pc),
        .ir       (instruction),
        .mdr      (mdr),
        .zHigh    (zHigh),
        .zLow     (zLow),
        .hi       (hi),
        .lo       (lo),
        .inPort   (inPort),
        .busData  (busData)
    );

endmodule

/* datapathTb.sv */
`include "datapath_defines.svh"

module datapathTb;

    timeunit 1ns;
    timeprecision 1ps;

    import datapathPkg::*;

    localparam string CasesFile = "datapath_cases.txt";
    localparam int    MaxCycles = 500;   // upper bound on applied lines

    logic                    Clock = 1'b0;
    logic                    reset;
    controlWord              control;
    logic [`WORD_WIDTH-1:0]  Mdatain;
    logic [`WORD_WIDTH-1:0]  inPort;
    logic [`WORD_WIDTH-1:0]  busData;
    logic [`WORD_WIDTH-1:0]  memoryAddress;
    logic [`WORD_WIDTH-1:0]  instruction;
    logic [`WORD_WIDTH-1:0]  outPort;

    int checkCount = 0;
    int errorCount = 0;
    int testCount  = 0;
    int testChecks = 0;
    int testErrors = 0;
    bit aborted    = 1'b0;   // set on timeout, missing file or bad line

    datapath datapath_i (
        .Clock         (Clock),
        .reset         (reset),
        .control       (control),
        .Mdatain       (Mdatain),
        .inPort        (inPort),
        .busData       (busData),
        .memoryAddress (memoryAddress),
        .instruction   (instruction),
        .outPort       (outPort)
    );

    always #5 Clock = ~Clock;   // 10 ns period

    // compare one DUT output with its expected value
    task automatic checkOutput(input string name, input logic [`WORD_WIDTH-1:0] expected,
                               input logic [`WORD_WIDTH-1:0] actual);
        checkCount++;
        testChecks++;
        assert (actual === expected) else begin
            $display("mismatch at %0d ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            errorCount++;
            testErrors++;
        end
    endtask

    // summary for a test number once all its lines are done
    task automatic closeTest(input int number);
        testCount++;
        $display("test %0d done: %0d checks, %0d errors", number, testChecks, testErrors);
        testChecks = 0;
        testErrors = 0;
    endtask

    // one line of the cases file per clock cycle
    task automatic runCases(input int fd);
        string                   line;
        int                      fields;
        int                      number;
        int                      currentTest;
        int                      cycles;
        logic [3:0]              source;
        logic [3:0]              regIndex;
        logic [15:0]             regLoad;
        logic [9:0]              flags;
        logic [4:0]              opcode;
        logic [`WORD_WIDTH-1:0]  memoryIn;
        logic [`WORD_WIDTH-1:0]  portIn;
        logic [3:0]              mask;
        logic [`WORD_WIDTH-1:0]  expBus;
        logic [`WORD_WIDTH-1:0]  expAddress;
        logic [`WORD_WIDTH-1:0]  expInstruction;
        logic [`WORD_WIDTH-1:0]  expOut;
        currentTest = -1;
        cycles = 0;
        while ($fgets(line, fd) != 0) begin
            if (cycles >= MaxCycles) begin
                $display("timeout: %s not finished after %0d cycles", CasesFile, MaxCycles);
                aborted = 1'b1;
                break;
            end
            // skip blank lines and comments
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%d %h %h %h %b %h %h %h %h %h %h %h %h",
                             number, source, regIndex, regLoad, flags, opcode,
                             memoryIn, portIn, mask,
                             expBus, expAddress, expInstruction, expOut);
            if (fields != 13) begin
                $display("cases file has a line that could not be read: %s", line);
                aborted = 1'b1;
                break;
            end
            if (number != currentTest) begin
                if (currentTest >= 0) begin
                    closeTest(currentTest);
                end
                currentTest = number;
            end

            @(posedge Clock);
            #1;   // drive just after the edge
            control.source   = busSource'(source);
            control.regIndex = regIndex;
            control.regLoad  = regLoad;
            {control.pcLoad, control.irLoad, control.marLoad, control.mdrLoad,
             control.read, control.yLoad, control.zLoad, control.hiLoad,
             control.loLoad, control.outPortLoad} = flags;
            control.opcode   = aluOpcode'(opcode);
            Mdatain          = memoryIn;
            inPort           = portIn;

            #7;   // sample well before the next edge
            if (mask[0]) begin
                checkOutput("busData", expBus, busData);
            end
            if (mask[1]) begin
                checkOutput("memoryAddress", expAddress, memoryAddress);
            end
            if (mask[2]) begin
                checkOutput("instruction", expInstruction, instruction);
            end
            if (mask[3]) begin
                checkOutput("outPort", expOut, outPort);
            end
            cycles++;
        end
        if (currentTest >= 0) begin
            closeTest(currentTest);
        end
    endtask

    task automatic finishRun();
        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0 && !aborted) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    initial begin
        int fd;
        reset   = 1'b1;
        control = '0;
        Mdatain = '0;
        inPort  = '0;

        for (int i = 0; i < 10; i++) begin
            @(posedge Clock);
        end
        #1;
        reset = 1'b0;

        fd = $fopen(CasesFile, "r");
        if (fd == 0) begin
            $display("could not open %s for reading", CasesFile);
            aborted = 1'b1;
        end else begin
            runCases(fd);
            $fclose(fd);
        end
        finishRun();
    end

endmodule

/* datapath_cases.txt */
# test src idx regLoad flags(pc ir mar mdr read y z hi lo out) op Mdatain inPort mask
# then expected busData memoryAddress instruction outPort, mask bit 0..3 picks each
01 0 0 0000 0000000000 00 00000000 00000000 f 00000000 00000000 00000000 00000000
02 0 0 0000 0001100000 00 00000012 00000000 0 00000000 00000000 00000000 00000000
02 3 0 0004 0001100000 00 00000014 00000000 1 00000012 00000000 00000000 00000000
02 3 0 0008 0001100000 00 00000018 00000000 1 00000014 00000000 00000000 00000000
02 3 0 0002 0000000000 00 00000000 00000000 1 00000018 00000000 00000000 00000000
02 1 2 0000 0000000000 00 00000000 00000000 1 00000012 00000000 00000000 00000000
02 1 3 0000 0000000000 00 00000000 00000000 1 00000014 00000000 00000000 00000000
02 1 1 0000 0000000000 00 00000000 00000000 1 00000018 00000000 00000000 00000000
03 1 2 0000 0000010000 00 00000000 00000000 1 00000012 00000000 00000000 00000000
03 1 3 0000 0000001000 00 00000000 00000000 1 00000014 00000000 00000000 00000000
03 5 0 0000 0000000000 00 00000000 00000000 1 00000010 00000000 00000000 00000000
03 1 3 0000 0000001000 01 00000000 00000000 1 00000014 00000000 00000000 00000000
03 5 0 0000 0000000000 00 00000000 00000000 1 00000016 00000000 00000000 00000000
03 1 3 0000 0000001000 02 00000000 00000000 1 00000014 00000000 00000000 00000000
03 5 0 0000 0000000000 00 00000000 00000000 1 00000026 00000000 00000000 00000000
03 1 3 0000 0000001000 03 00000000 00000000 1 00000014 00000000 00000000 00000000
03 5 0 0000 0000000000 00 00000000 00000000 1 fffffffe 00000000 00000000 00000000
03 8 0 0000 0000010000 00 00000000 800000f1 1 800000f1 00000000 00000000 00000000
03 8 0 0000 0000001000 04 00000000 00000024 1 00000024 00000000 00000000 00000000
03 5 0 0000 0000000000 00 00000000 00000000 1 00000f10 00000000 00000000 00000000
03 8 0 0000 0000001000 05 00000000 00000024 1 00000024 00000000 00000000 00000000
03 5 0 0000 0000000000 00 00000000 00000000 1 0800000f 00000000 00000000 00000000
03 8 0 0000 0000001000 06 00000000 00000024 1 00000024 00000000 00000000 00000000
03 5 0 0000 0000000000 00 00000000 00000000 1 f800000f 00000000 00000000 00000000
03 8 0 0000 0000001000 07 00000000 00000024 1 00000024 00000000 00000000 00000000
03 5 0 0000 0000000000 00 00000000 00000000 1 00000f18 00000000 00000000 00000000
03 8 0 0000 0000001000 08 00000000 00000024 1 00000024 00000000 00000000 00000000
03 5 0 0000 0000000000 00 00000000 00000000 1 1800000f 00000000 00000000 00000000
03 1 3 0000 0000001000 09 00000000 00000000 1 00000014 00000000 00000000 00000000
03 5 0 0000 0000000000 00 00000000 00000000 1 ffffffeb 00000000 00000000 00000000
03 1 3 0000 0000001000 0a 00000000 00000000 1 00000014 00000000 00000000 00000000
03 5 0 0000 0000000000 00 00000000 00000000 1 ffffffec 00000000 00000000 00000000
04 8 0 0000 0000010000 00 00000000 fffffffa 1 fffffffa 00000000 00000000 00000000
04 8 0 0000 0000001000 0b 00000000 10000000 1 10000000 00000000 00000000 00000000
04 4 0 0000 0000000100 00 00000000 00000000 1 ffffffff 00000000 00000000 00000000
04 5 0 0000 0000000010 00 00000000 00000000 1 a0000000 00000000 00000000 00000000
04 6 0 0000 0000000000 00 00000000 00000000 1 ffffffff 00000000 00000000 00000000
04 7 0 0000 0000000000 00 00000000 00000000 1 a0000000 00000000 00000000 00000000
04 8 0 0000 0000001000 0b 00000000 c0000000 1 c0000000 00000000 00000000 00000000
04 4 0 0000 0000000000 00 00000000 00000000 1 00000001 00000000 00000000 00000000
04 5 0 0000 0000000000 00 00000000 00000000 1 80000000 00000000 00000000 00000000
05 8 0 0000 1000000000 00 00000000 00000040 1 00000040 00000000 00000000 00000000
05 2 0 0000 0010001000 0c 00000000 00000000 1 00000040 00000000 00000000 00000000
05 5 0 0000 1001100000 00 28918000 00000000 3 00000041 00000040 00000000 00000000
05 3 0 0000 0100000000 00 00000000 00000000 1 28918000 00000000 00000000 00000000
05 2 0 0000 0000000000 00 00000000 00000000 7 00000041 00000040 28918000 00000000
06 9 0 0000 0000000000 00 00000000 00000000 1 00018000 00000000 00000000 00000000
06 8 0 0000 0100000000 00 00000000 0007fff0 1 0007fff0 00000000 00000000 00000000
06 9 0 0000 0000000000 00 00000000 00000000 5 fffffff0 00000000 0007fff0 00000000
06 8 0 0000 0000000001 00 00000000 cafe0123 9 cafe0123 00000000 00000000 00000000
06 0 0 0000 0000000000 00 00000000 00000000 9 00000000 00000000 00000000 cafe0123

/* files.f */
+incdir+.
datapathPkg.sv
registerFile.sv
arithLogicUnit.sv
specialRegisters.sv
busSelector.sv
datapath.sv
datapathTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= datapathTb
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --assert --timescale 1ns/1ps
PASS_TEXT ?= NO ERRORS

SOURCES := datapath_defines.svh datapathPkg.sv registerFile.sv arithLogicUnit.sv \
           specialRegisters.sv busSelector.sv datapath.sv datapathTb.sv
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass message shows up in the output
run: $(SIM) datapath_cases.txt
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
